/* bench/port_wr_chk.sv */
`timescale 1ns/1ps
`default_nettype none
`include "port_consts.svh"

module port_wr_chk (
    input logic                clk,
    input logic                rst_n,
    input port_pkg::sram_wr_t  sram_wr,
    input logic                desc_vld,
    input port_pkg::pkt_desc_t desc
);

    // Descriptor strobe is a single cycle pulse.
    desc_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
        desc_vld |=> !desc_vld)
        else $error("desc_vld stayed high for more than one cycle");

    sram_quiet_in_reset_a: assert property (@(posedge clk)
        !rst_n |-> !sram_wr.en)
        else $error("sram_wr.en high while reset is asserted");

    // The last write of a packet still lies inside its bank.
    sram_addr_range_a: assert property (@(posedge clk) disable iff (!rst_n)
        desc_vld |-> (int'(desc.grant.base) + int'(desc.info.length) < `PORT_BANK_DEPTH))
        else $error("a packet runs past the end of its bank");

endmodule

`default_nettype wire

/* bench/port_wr_input.txt */
// Columns (hex): dest prior length expected_bank expected_base
// Lengths add up so that all four banks end exactly full.
3 5 13F 0 000
7 2 0FF 1 000
A 7 07F 0 140
1 0 0FF 1 100
F 3 003 0 1C0
5 6 1FF 2 000
C 1 03B 0 1C4
2 4 001 3 000
9 7 0C7 3 002
0 2 00F 3 0CA
6 5 07F 3 0DA
B 1 03F 3 15A
4 3 02F 3 19A
E 6 02F 3 1CA
8 0 005 3 1FA

/* bench/port_wr_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "port_consts.svh"

module port_wr_tb;
    import port_pkg::*;

    localparam int NPKT          = 15;
    localparam int REC_WORDS     = 5;      // Words per line of the input file.
    localparam int RST_CYCLES    = 4;
    localparam int SEED          = 53707;
    localparam int DESC_TIMEOUT  = 2000;   // Cycles allowed per descriptor.
    localparam int PAUSE_TIMEOUT = 200;
    localparam int TAIL_CYCLES   = 20;     // Quiet cycles watched after the last descriptor.

    // One packet line of the input file.
    typedef struct packed {
        logic [3:0]               dest;
        logic [2:0]               prior;
        logic [8:0]               length;
        logic [BANK_IW-1:0]       bank;    // Expected grant.
        logic [`PORT_BANK_AW-1:0] base;
    } pkt_rec_t;

    typedef struct packed {
        pkt_rec_t    rec;
        logic [15:0] csum;
    } sent_pkt_t;

    logic        clk;
    logic        rst_n;
    logic        wr_sop;
    logic        wr_vld;
    logic [15:0] wr_data;
    logic        wr_eop;
    logic        pause;
    sram_wr_t    sram_wr;
    logic        desc_vld;
    pkt_desc_t   desc;

    logic [15:0] file_words [NPKT*REC_WORDS];
    pkt_rec_t    recs [NPKT];
    sent_pkt_t   sent_q [$];               // Sent packets with the oldest at the front.
    logic [15:0] sent_words [$];           // Header and payload of every sent packet.
    sram_wr_t    wr_log [$];               // SRAM writes not yet matched to a packet.
    logic        pause_seen;

    port_wr_top uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_sop   (wr_sop),
        .wr_vld   (wr_vld),
        .wr_data  (wr_data),
        .wr_eop   (wr_eop),
        .pause    (pause),
        .sram_wr  (sram_wr),
        .desc_vld (desc_vld),
        .desc     (desc)
    );

    bind port_wr_top port_wr_chk u_chk (
        .clk      (clk),
        .rst_n    (rst_n),
        .sram_wr  (sram_wr),
        .desc_vld (desc_vld),
        .desc     (desc)
    );

    always #50 clk = ~clk;

    task automatic report_mismatch(input string test, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", test, expected, actual);
        $display("Errors found");
        $fatal(1, "Simulation stopped on the first failing check.");
    endtask

    task automatic report_failure(input string what);
        $display("[ERROR] %s", what);
        $display("Errors found");
        $fatal(1, "Simulation stopped on the first failing check.");
    endtask

    task automatic check_quiet(input string test);
        assert (!pause && !desc_vld && !sram_wr.en)
            else report_mismatch(test, 32'd0, {29'd0, pause, desc_vld, sram_wr.en});
    endtask

    // Header, random payload and checksum go to the model before the first word is driven.
    task automatic send_packet(input pkt_rec_t rec);
        logic [15:0] words [$];
        logic [15:0] word;
        logic [15:0] csum;
        logic        hold;
        int          idx;
        int          stall;
        word = {rec.length, rec.prior, rec.dest};
        words.push_back(word);
        csum = word;
        for (int i = 0; i < rec.length; i++) begin
            word = 16'($urandom());
            words.push_back(word);
            csum = csum ^ word;
        end
        foreach (words[i]) begin
            sent_words.push_back(words[i]);
        end
        sent_q.push_back('{rec: rec, csum: csum});
        idx   = 0;
        stall = 0;
        while (idx < words.size()) begin
            @(negedge clk);
            hold = pause;                  // Source must hold off while paused.
            @(posedge clk);
            if (hold) begin
                wr_vld <= 1'b0;
                wr_sop <= 1'b0;
                wr_eop <= 1'b0;
                stall++;
                assert (stall < PAUSE_TIMEOUT)
                    else report_failure("pause stayed high too long, the source never resumed");
            end else begin
                wr_vld  <= 1'b1;
                wr_sop  <= (idx == 0);
                wr_eop  <= (idx == words.size() - 1);
                wr_data <= words[idx];
                idx++;
                stall = 0;
            end
        end
    endtask

    task automatic send_all();
        for (int k = 0; k < NPKT; k++) begin
            send_packet(recs[k]);          // Back to back with no idle cycle between packets.
        end
        @(posedge clk);
        wr_vld <= 1'b0;
        wr_sop <= 1'b0;
        wr_eop <= 1'b0;
    endtask

    // Logs SRAM writes and pause every cycle until the next descriptor.
    task automatic wait_desc();
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen) begin
            @(negedge clk);
            if (pause) begin
                pause_seen = 1'b1;
            end
            if (sram_wr.en) begin
                wr_log.push_back(sram_wr);
            end
            if (desc_vld) begin
                seen = 1'b1;
            end else begin
                cycles++;
                assert (cycles < DESC_TIMEOUT)
                    else report_failure("no descriptor arrived within the timeout");
            end
        end
    endtask

    task automatic check_packet(input int k);
        sent_pkt_t   exp_pkt;
        sram_wr_t    wr;
        logic [15:0] exp_word;
        assert (sent_q.size() > 0)
            else report_failure("a descriptor arrived with no packet outstanding");
        exp_pkt = sent_q.pop_front();
        assert (desc.info.length == exp_pkt.rec.length)
            else report_mismatch($sformatf("header_decode length pkt%0d", k),
                                 exp_pkt.rec.length, desc.info.length);
        assert (desc.info.prior == exp_pkt.rec.prior)
            else report_mismatch($sformatf("header_decode prior pkt%0d", k),
                                 exp_pkt.rec.prior, desc.info.prior);
        assert (desc.info.dest == exp_pkt.rec.dest)
            else report_mismatch($sformatf("header_decode dest pkt%0d", k),
                                 exp_pkt.rec.dest, desc.info.dest);
        assert (desc.grant.bank == exp_pkt.rec.bank)
            else report_mismatch($sformatf("first_fit bank pkt%0d", k),
                                 exp_pkt.rec.bank, desc.grant.bank);
        assert (desc.grant.base == exp_pkt.rec.base)
            else report_mismatch($sformatf("first_fit base pkt%0d", k),
                                 exp_pkt.rec.base, desc.grant.base);
        assert (desc.csum == exp_pkt.csum)
            else report_mismatch($sformatf("checksum pkt%0d", k), exp_pkt.csum, desc.csum);
        for (int i = 0; i <= exp_pkt.rec.length; i++) begin
            assert (wr_log.size() > 0)
                else report_failure($sformatf("pkt%0d is missing SRAM write %0d", k, i));
            wr       = wr_log.pop_front();
            exp_word = sent_words.pop_front();
            assert (wr.bank == exp_pkt.rec.bank)
                else report_mismatch($sformatf("stored_data bank pkt%0d word%0d", k, i),
                                     exp_pkt.rec.bank, wr.bank);
            assert (wr.addr == exp_pkt.rec.base + `PORT_BANK_AW'(i))
                else report_mismatch($sformatf("stored_data addr pkt%0d word%0d", k, i),
                                     exp_pkt.rec.base + `PORT_BANK_AW'(i), wr.addr);
            assert (wr.data == exp_word)
                else report_mismatch($sformatf("stored_data data pkt%0d word%0d", k, i),
                                     exp_word, wr.data);
        end
        assert (wr_log.size() == 0)
            else report_mismatch($sformatf("stored_data extra writes pkt%0d", k),
                                 32'd0, wr_log.size());
    endtask

    task automatic collect_all();
        for (int k = 0; k < NPKT; k++) begin
            wait_desc();
            check_packet(k);
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        wr_sop     = 1'b0;
        wr_vld     = 1'b0;
        wr_eop     = 1'b0;
        wr_data    = '0;
        pause_seen = 1'b0;
        void'($urandom(SEED));
        for (int i = 0; i < NPKT*REC_WORDS; i++) begin
            file_words[i] = 16'hF000 | 16'(i);     // No file entry sets the top nibble.
        end
        $readmemh("bench/port_wr_input.txt", file_words);
        assert (file_words[NPKT*REC_WORDS-1][15:12] == 4'h0)
            else report_failure("the input file is missing or holds too few packets");
        for (int k = 0; k < NPKT; k++) begin
            recs[k].dest   = file_words[REC_WORDS*k][3:0];
            recs[k].prior  = file_words[REC_WORDS*k+1][2:0];
            recs[k].length = file_words[REC_WORDS*k+2][8:0];
            recs[k].bank   = file_words[REC_WORDS*k+3][BANK_IW-1:0];
            recs[k].base   = file_words[REC_WORDS*k+4][`PORT_BANK_AW-1:0];
        end

        for (int i = 0; i < RST_CYCLES; i++) begin
            @(negedge clk);
            check_quiet("reset_state during reset");
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_quiet("reset_state after reset");

        fork
            send_all();
            collect_all();
        join

        // The long run into the high banks must have filled the ring.
        assert (pause_seen)
            else report_failure("back_pressure: pause never rose during the back to back run");

        // Nothing more leaves the DUT once every packet is stored.
        repeat (TAIL_CYCLES) begin
            @(negedge clk);
            assert (!desc_vld && !sram_wr.en)
                else report_failure("a descriptor or SRAM write followed the last packet");
        end
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

/* build.sh */
#!/bin/sh
# Compiles the testbench with Verilator, runs it and scans sim.log for the failure line.
# A failed build or a simulator error exit also counts as a failure.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal --top-module port_wr_tb \
    -f filelist.f -o port_wr_sim > sim.log 2>&1 \
    && ./obj_dir/port_wr_sim >> sim.log 2>&1 \
    || echo "Errors found" >> sim.log

grep -q "Errors found" sim.log \
    && { echo "Simulation FAILED, see sim.log"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }

/* filelist.f */
+incdir+logic
logic/port_pkg.sv
logic/port_wr_frontend.sv
logic/port_sram_matcher.sv
logic/port_backend.sv
logic/port_wr_top.sv
bench/port_wr_chk.sv
bench/port_wr_tb.sv

/* logic/port_backend.sv */
`timescale 1ns/1ps
`default_nettype none
`include "port_consts.svh"

module port_backend (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   match_suc,
    input  port_pkg::match_grant_t grant,
    input  port_pkg::pkt_info_t    cur_info,
    input  logic [15:0]            xfer_data,
    input  logic                   xfer_data_vld,
    output port_pkg::sram_wr_t     sram_wr,
    output logic                   desc_vld,
    output port_pkg::pkt_desc_t    desc
);
    import port_pkg::*;

    localparam int LW = `PORT_HDR_LEN_MSB - `PORT_HDR_LEN_LSB + 1;

    match_grant_t             cur_grant;
    logic [LW-1:0]            wr_cnt;      // Word index in the packet, header is 0.
    logic [15:0]              csum;
    logic                     wr_done;
    logic                     en_q;
    logic [BANK_IW-1:0]       bank_q;
    logic [`PORT_BANK_AW-1:0] addr_q;
    logic [15:0]              data_q;

    // Word number length is the last one.
    assign wr_done = xfer_data_vld && (wr_cnt == cur_info.length);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_cnt   <= '0;
            en_q     <= 1'b0;
            desc_vld <= 1'b0;
        end else begin
            en_q     <= xfer_data_vld;
            desc_vld <= wr_done;
            if (match_suc) begin
                wr_cnt <= '0;
            end else if (xfer_data_vld) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (match_suc) begin
            cur_grant <= grant;
            csum      <= '0;
        end else if (xfer_data_vld) begin
            csum <= csum ^ xfer_data;
        end
        if (xfer_data_vld) begin
            bank_q <= cur_grant.bank;
            addr_q <= cur_grant.base + `PORT_BANK_AW'(wr_cnt);
            data_q <= xfer_data;
        end
        if (wr_done) begin
            // Fold in the last word so the sum lines up with the final write.
            desc <= '{info: cur_info, grant: cur_grant, csum: csum ^ xfer_data};
        end
    end

    assign sram_wr = '{en: en_q, bank: bank_q, addr: addr_q, data: data_q};

endmodule

`default_nettype wire

/* logic/port_consts.svh */
`ifndef PORT_CONSTS_SVH
`define PORT_CONSTS_SVH

// Frontend ring buffer.
`define PORT_BUF_DEPTH     64
`define PORT_BUF_AW        6
`define PORT_PAUSE_MARGIN  2    // Free slots left when pause is raised.

// Shared SRAM.
`define PORT_BANK_NUM      4
`define PORT_BANK_DEPTH    512  // Words per bank.
`define PORT_BANK_AW       9

// Header word layout.
`define PORT_HDR_LEN_MSB   15
`define PORT_HDR_LEN_LSB   7
`define PORT_HDR_PRI_MSB   6
`define PORT_HDR_PRI_LSB   4
`define PORT_HDR_DST_MSB   3
`define PORT_HDR_DST_LSB   0

`endif

/* logic/port_pkg.sv */
`default_nettype none
`include "port_consts.svh"

package port_pkg;

    localparam int BANK_IW = $clog2(`PORT_BANK_NUM);

    // Decoded header word.
    typedef struct packed {
        logic [`PORT_HDR_LEN_MSB-`PORT_HDR_LEN_LSB:0] length; // Payload words, header excluded.
        logic [`PORT_HDR_PRI_MSB-`PORT_HDR_PRI_LSB:0] prior;
        logic [`PORT_HDR_DST_MSB-`PORT_HDR_DST_LSB:0] dest;
    } pkt_info_t;

    typedef struct packed {
        logic [BANK_IW-1:0]       bank;
        logic [`PORT_BANK_AW-1:0] base;  // First word of the packet in the bank.
    } match_grant_t;

    // One SRAM write strobe.
    typedef struct packed {
        logic                     en;
        logic [BANK_IW-1:0]       bank;
        logic [`PORT_BANK_AW-1:0] addr;
        logic [15:0]              data;
    } sram_wr_t;

    // Completion descriptor of a stored packet.
    typedef struct packed {
        pkt_info_t    info;
        match_grant_t grant;
        logic [15:0]  csum;                // XOR of every stored word.
    } pkt_desc_t;

    typedef enum logic [1:0] {
        WR_IDLE,                           // Waiting for a header word.
        WR_HEAD,                           // Header taken, first payload word next.
        WR_BODY,
        WR_TAIL                            // Next valid word is the last one.
    } wr_state_e;

    typedef enum logic [1:0] {
        XF_IDLE,
        XF_RUN,
        XF_STALL                           // Ring ran empty mid packet.
    } xfer_state_e;

    typedef enum logic [1:0] {
        M_IDLE,
        M_SCAN,
        M_GRANT
    } match_state_e;

endpackage

`default_nettype wire

/* logic/port_sram_matcher.sv */
`timescale 1ns/1ps
`default_nettype none
`include "port_consts.svh"

module port_sram_matcher (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   match_req,
    input  port_pkg::pkt_info_t    new_info,
    output logic                   match_suc,
    output port_pkg::match_grant_t grant
);
    import port_pkg::*;

    localparam int FW = `PORT_BANK_AW + 1;      // Fill level can reach the bank depth.

    match_state_e       m_state;
    logic [BANK_IW-1:0] scan_idx;               // Bank under test this cycle.
    logic [FW-1:0]      fill [`PORT_BANK_NUM];
    logic [FW-1:0]      need;
    logic [FW-1:0]      room;
    logic               fits;

    assign room      = FW'(`PORT_BANK_DEPTH) - fill[scan_idx];
    assign fits      = (room >= need);
    assign match_suc = (m_state == M_GRANT);

    // First fit from bank 0, one bank per cycle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_state  <= M_IDLE;
            scan_idx <= '0;
            for (int i = 0; i < `PORT_BANK_NUM; i++) begin
                fill[i] <= '0;
            end
        end else begin
            case (m_state)
                M_IDLE: if (match_req) begin
                    scan_idx <= '0;
                    m_state  <= M_SCAN;
                end
                M_SCAN: begin
                    if (fits) begin
                        fill[scan_idx] <= fill[scan_idx] + need;
                        m_state        <= M_GRANT;
                    end else begin
                        // Wraps back to bank 0 and keeps looking.
                        scan_idx <= scan_idx + 1'b1;
                    end
                end
                M_GRANT: m_state <= M_IDLE;
                default: m_state <= M_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (match_req && m_state == M_IDLE) begin
            need <= FW'(new_info.length) + 1'b1;   // Payload plus header word.
        end
        if (m_state == M_SCAN && fits) begin
            grant.bank <= scan_idx;
            grant.base <= fill[scan_idx][`PORT_BANK_AW-1:0];
        end
    end

endmodule

`default_nettype wire

/* logic/port_wr_frontend.sv */
`timescale 1ns/1ps
`default_nettype none
`include "port_consts.svh"

module port_wr_frontend (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr_sop,
    input  logic                wr_vld,
    input  logic [15:0]         wr_data,
    input  logic                wr_eop,
    output logic                pause,
    output logic                match_req,
    output port_pkg::pkt_info_t new_info,
    input  logic                match_suc,
    output logic [15:0]         xfer_data,
    output logic                xfer_data_vld,
    output port_pkg::pkt_info_t cur_info
);
    import port_pkg::*;

    localparam int AW = `PORT_BUF_AW;
    localparam int PW = `PORT_BUF_AW + 1;                     // Pointer plus wrap bit.
    localparam int LW = `PORT_HDR_LEN_MSB - `PORT_HDR_LEN_LSB + 1;

    wr_state_e   wr_state;
    xfer_state_e xf_state;

    logic [15:0]   buf_mem  [`PORT_BUF_DEPTH];
    logic          buf_last [`PORT_BUF_DEPTH];            // Marks the final word of a packet.

    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW-1:0] used;
    logic          ring_empty;
    logic [LW-1:0] wr_left;                               // Payload words still expected.
    logic          wr_take;
    logic          wr_last;
    logic          rd_go;
    logic          req_pend;
    logic          req_go;
    logic [15:0]   hdr_word;

    // Words outside a packet are dropped.
    assign wr_take = wr_vld && (wr_state != WR_IDLE || wr_sop);
    assign wr_last = wr_vld && wr_eop && (wr_state == WR_TAIL);

    assign used       = wr_ptr - rd_ptr;
    assign ring_empty = (wr_ptr == rd_ptr);

    // Intake FSM. The length count arms the tail and eop closes it.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_state <= WR_IDLE;
            wr_left  <= '0;
        end else if (wr_vld) begin
            case (wr_state)
                WR_IDLE: if (wr_sop) begin
                    wr_left  <= wr_data[`PORT_HDR_LEN_MSB:`PORT_HDR_LEN_LSB];
                    wr_state <= (wr_data[`PORT_HDR_LEN_MSB:`PORT_HDR_LEN_LSB] == LW'(1)) ?
                                WR_TAIL : WR_HEAD;
                end
                WR_HEAD, WR_BODY: begin
                    wr_left  <= wr_left - 1'b1;
                    wr_state <= (wr_left == LW'(2)) ? WR_TAIL : WR_BODY;
                end
                WR_TAIL: if (wr_eop) begin
                    wr_state <= WR_IDLE;
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_take) begin
            buf_mem[wr_ptr[AW-1:0]]  <= wr_data;
            buf_last[wr_ptr[AW-1:0]] <= wr_last;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            pause  <= 1'b0;
        end else begin
            if (wr_take) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            pause <= (used >= PW'(`PORT_BUF_DEPTH - `PORT_PAUSE_MARGIN));
        end
    end

    // The next header sits at the read pointer once the drain is idle.
    // An empty ring takes it straight from the bus.
    assign hdr_word = ring_empty ? wr_data : buf_mem[rd_ptr[AW-1:0]];
    assign req_go   = !req_pend && (xf_state == XF_IDLE) &&
                      (!ring_empty || (wr_vld && wr_sop && wr_state == WR_IDLE));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            match_req <= 1'b0;
            req_pend  <= 1'b0;
        end else begin
            match_req <= req_go;
            if (req_go) begin
                req_pend <= 1'b1;
            end else if (match_suc) begin
                req_pend <= 1'b0;
            end
        end
    end

    // Drain FSM, one word per cycle while the ring holds data.
    assign rd_go = (xf_state != XF_IDLE) && !ring_empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            xf_state      <= XF_IDLE;
            rd_ptr        <= '0;
            xfer_data_vld <= 1'b0;
        end else begin
            xfer_data_vld <= rd_go;
            if (rd_go) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case (xf_state)
                XF_IDLE: if (match_suc) begin
                    xf_state <= XF_RUN;
                end
                XF_RUN, XF_STALL: begin
                    if (rd_go && buf_last[rd_ptr[AW-1:0]]) begin
                        xf_state <= XF_IDLE;               // Packet end reached.
                    end else begin
                        xf_state <= rd_go ? XF_RUN : XF_STALL;
                    end
                end
                default: xf_state <= XF_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_go) begin
            new_info.length <= hdr_word[`PORT_HDR_LEN_MSB:`PORT_HDR_LEN_LSB];
            new_info.prior  <= hdr_word[`PORT_HDR_PRI_MSB:`PORT_HDR_PRI_LSB];
            new_info.dest   <= hdr_word[`PORT_HDR_DST_MSB:`PORT_HDR_DST_LSB];
        end
        if (match_suc) begin
            cur_info <= new_info;
        end
        if (rd_go) begin
            xfer_data <= buf_mem[rd_ptr[AW-1:0]];
        end
    end

endmodule

`default_nettype wire

/* logic/port_wr_top.sv */
`timescale 1ns/1ps
`default_nettype none

module port_wr_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr_sop,
    input  logic                wr_vld,
    input  logic [15:0]         wr_data,
    input  logic                wr_eop,
    output logic                pause,
    output port_pkg::sram_wr_t  sram_wr,
    output logic                desc_vld,
    output port_pkg::pkt_desc_t desc
);
    import port_pkg::*;

    pkt_info_t    new_info;     // Header under allocation.
    pkt_info_t    cur_info;     // Header of the packet being stored.
    match_grant_t grant;
    logic         match_req;
    logic         match_suc;
    logic [15:0]  xfer_data;
    logic         xfer_data_vld;

    port_wr_frontend u_frontend (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_sop        (wr_sop),
        .wr_vld        (wr_vld),
        .wr_data       (wr_data),
        .wr_eop        (wr_eop),
        .pause         (pause),
        .match_req     (match_req),
        .new_info      (new_info),
        .match_suc     (match_suc),
        .xfer_data     (xfer_data),
        .xfer_data_vld (xfer_data_vld),
        .cur_info      (cur_info)
    );

    port_sram_matcher u_matcher (
        .clk       (clk),
        .rst_n     (rst_n),
        .match_req (match_req),
        .new_info  (new_info),
        .match_suc (match_suc),
        .grant     (grant)
    );

    port_backend u_backend (
        .clk           (clk),
        .rst_n         (rst_n),
        .match_suc     (match_suc),
        .grant         (grant),
        .cur_info      (cur_info),
        .xfer_data     (xfer_data),
        .xfer_data_vld (xfer_data_vld),
        .sram_wr       (sram_wr),
        .desc_vld      (desc_vld),
        .desc          (desc)
    );

endmodule

`default_nettype wire
